//--- all.f
source/ara_sys_pkg.sv
source/cluster_cmd_if.sv
source/cmd_fork_node.sv
source/ring_spill.sv
source/vec_cluster.sv
source/cluster_ctrl.sv
source/vec_cluster_sys.sv
verification/tb_vec_cluster_sys.sv

//--- Bender.yml
package:
  name: vec_cluster_sys

sources:
  - source/ara_sys_pkg.sv
  - source/cluster_cmd_if.sv
  - source/cmd_fork_node.sv
  - source/ring_spill.sv
  - source/vec_cluster.sv
  - source/cluster_ctrl.sv
  - source/vec_cluster_sys.sv
  - target: test
    files:
      - verification/tb_vec_cluster_sys.sv

//--- verification/tb_vec_cluster_sys.sv
`timescale 1ns/100ps

module tb_vec_cluster_sys;

  logic        clk_i;
  logic        rst_i;
  logic        cmd_valid_i;
  logic        cmd_ready_o;
  logic [31:0] cmd_i;
  logic        rsp_valid_o;
  logic        rsp_ready_i;
  logic [31:0] rsp_data_o;

  // Reference copy of the distributed vector and responses still owed
  logic [31:0] model [ara_sys_pkg::NrClusters];
  logic [31:0] exp_q [$];

  logic [31:0] lfsr_q;
  logic        stall_en;
  logic        abort;
  int unsigned checks;
  int unsigned errors;
  int unsigned test_num;
  int unsigned test_err_base;

  vec_cluster_sys DUT (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_i       (cmd_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_data_o  (rsp_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h8020_0003;
    else return s >> 1;
  endfunction

  // One LFSR step per bit with the newest bit in the LSB
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  task automatic apply_model(input logic [31:0] word);
    logic [3:0]  op;
    logic [3:0]  tgt;
    logic [31:0] incr;
    logic [31:0] last;
    op   = word[31:28];
    tgt  = word[27:24];
    incr = 32'($signed(word[27:0]));
    case (op)
      ara_sys_pkg::OP_LOAD: begin
        if (tgt < ara_sys_pkg::NrClusters) model[tgt] = 32'(word[23:0]);
        exp_q.push_back(32'h0);
      end
      ara_sys_pkg::OP_READ: begin
        if (tgt < ara_sys_pkg::NrClusters) exp_q.push_back(model[tgt]);
        else exp_q.push_back(32'h0);
      end
      ara_sys_pkg::OP_ADD: begin
        for (int i = 0; i < ara_sys_pkg::NrClusters; i++) model[i] = model[i] + incr;
        exp_q.push_back(32'h0);
      end
      default: begin
        // Rotate toward higher index so the top element wraps to cluster 0
        last = model[ara_sys_pkg::NrClusters-1];
        for (int i = ara_sys_pkg::NrClusters - 1; i > 0; i--) model[i] = model[i-1];
        model[0] = last;
        exp_q.push_back(32'h0);
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Cycle stepping, command driver, response checker
  ////////////////////////////////////////////////////////////////////////////

  // Transfer on the next rising edge if valid and ready are both high now
  task automatic next_cycle();
    logic [31:0] r;
    logic [31:0] exp;
    @(negedge clk_i);
    r = rand_bits(1);
    rsp_ready_i = stall_en ? r[0] : 1'b1;
    if (rsp_valid_o && rsp_ready_i) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Response 0x%08h arrived with no command outstanding", rsp_data_o);
      end else begin
        exp = exp_q.pop_front();
        checks++;
        if (rsp_data_o !== exp) begin
          errors++;
          $display("[ERROR] rsp_data_o expected 0x%08h actual 0x%08h", exp, rsp_data_o);
        end
      end
    end
  endtask

  task automatic send_cmd(input logic [31:0] word);
    int unsigned waited;
    waited = 0;
    if (abort) return;
    cmd_valid_i = 1'b1;
    cmd_i       = word;
    while (!cmd_ready_o && waited < 1000) begin
      next_cycle();
      waited++;
    end
    if (!cmd_ready_o) begin
      errors++;
      abort       = 1'b1;
      cmd_valid_i = 1'b0;
      $display("Timeout: command 0x%08h was not accepted within 1000 cycles", word);
    end else begin
      apply_model(word);
      next_cycle();
      cmd_valid_i = 1'b0;
    end
  endtask

  task automatic drain();
    int unsigned waited;
    waited = 0;
    if (abort) return;
    while (exp_q.size() != 0 && waited < 2000) begin
      next_cycle();
      waited++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      abort = 1'b1;
      $display("Timeout: %0d responses still missing after 2000 cycles", exp_q.size());
    end
  endtask

  task automatic read_all();
    for (int i = 0; i < ara_sys_pkg::NrClusters; i++) begin
      send_cmd({ara_sys_pkg::OP_READ, 4'(i), 24'h0});
    end
  endtask

  task automatic finish_test(input string name);
    test_num++;
    $display("Test %0d %s finished with %0d errors", test_num, name, errors - test_err_base);
    test_err_base = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [31:0] word;
    logic [3:0]  op;
    lfsr_q        = 32'd73193;
    rst_i         = 1'b1;
    cmd_valid_i   = 1'b0;
    cmd_i         = '0;
    rsp_ready_i   = 1'b0;
    stall_en      = 1'b0;
    abort         = 1'b0;
    checks        = 0;
    errors        = 0;
    test_num      = 0;
    test_err_base = 0;
    for (int i = 0; i < ara_sys_pkg::NrClusters; i++) model[i] = '0;

    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    checks += 2;
    if (cmd_ready_o !== 1'b0) begin
      errors++;
      $display("[ERROR] cmd_ready_o expected 0x0 actual 0x%0h", cmd_ready_o);
    end
    if (rsp_valid_o !== 1'b0) begin
      errors++;
      $display("[ERROR] rsp_valid_o expected 0x0 actual 0x%0h", rsp_valid_o);
    end
    rst_i = 1'b0;

    read_all();
    drain();
    finish_test("reset and zero read");

    // Zero extension of the 24-bit value
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < ara_sys_pkg::NrClusters; i++) begin
        r = rand_bits(24);
        send_cmd({ara_sys_pkg::OP_LOAD, 4'(i), r[23:0]});
      end
      read_all();
    end
    drain();
    finish_test("load and read back");

    for (int n = 0; n < 8; n++) begin
      r = rand_bits(28);
      send_cmd({ara_sys_pkg::OP_ADD, r[27:0]});
      if (n % 2 == 1) read_all();
    end
    drain();
    finish_test("signed add");

    for (int i = 0; i < ara_sys_pkg::NrClusters; i++) begin
      r = rand_bits(24);
      send_cmd({ara_sys_pkg::OP_LOAD, 4'(i), r[23:0]});
    end
    for (int k = 0; k <= ara_sys_pkg::NrClusters; k++) begin
      send_cmd({ara_sys_pkg::OP_SLIDE, 28'h0});
      read_all();
    end
    drain();
    finish_test("ring slide");

    // Targets past the last cluster
    for (int t = ara_sys_pkg::NrClusters; t < 16; t++) begin
      r = rand_bits(24);
      send_cmd({ara_sys_pkg::OP_LOAD, 4'(t), r[23:0]});
      send_cmd({ara_sys_pkg::OP_READ, 4'(t), 24'h0});
    end
    read_all();
    drain();
    finish_test("out of range target");

    stall_en = 1'b1;
    for (int n = 0; n < 200; n++) begin
      r  = rand_bits(2);
      op = r[3:0];
      if (op == ara_sys_pkg::OP_LOAD || op == ara_sys_pkg::OP_READ) begin
        r    = rand_bits(27);
        word = {op, 1'b0, r[26:0]};
      end else begin
        r    = rand_bits(28);
        word = {op, r[27:0]};
      end
      send_cmd(word);
    end
    drain();
    stall_en = 1'b0;
    read_all();
    drain();
    // No extra response may follow
    if (!abort) repeat (20) next_cycle();
    finish_test("random mix with stalls");

    $display("Tests: %0d, checks: %0d, errors: %0d", test_num, checks, errors);
    if (errors == 0 && !abort) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- source/vec_cluster_sys.sv
`timescale 1ns/100ps

module vec_cluster_sys (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        cmd_valid_i,
  output logic        cmd_ready_o,
  input  logic [31:0] cmd_i,
  output logic        rsp_valid_o,
  input  logic        rsp_ready_i,
  output logic [31:0] rsp_data_o
);

  // Tree links numbered as a heap, 1 is the root, leaves follow the nodes
  cluster_cmd_if tree_if [1:2*ara_sys_pkg::NrClusters-1] ();

  // Ring links, tx side before the spill, rx side after it
  logic               tx_valid [ara_sys_pkg::NrClusters];
  logic               tx_ready [ara_sys_pkg::NrClusters];
  ara_sys_pkg::elem_t tx_data  [ara_sys_pkg::NrClusters];
  logic               rx_valid [ara_sys_pkg::NrClusters];
  logic               rx_ready [ara_sys_pkg::NrClusters];
  ara_sys_pkg::elem_t rx_data  [ara_sys_pkg::NrClusters];

  cluster_ctrl i_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_i       (cmd_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_data_o  (rsp_data_o),
    .tree_o      (tree_if[1])
  );

  ////////////////////////////////////////////////////////////////////////////
  // Fork tree
  ////////////////////////////////////////////////////////////////////////////

  for (genvar l = 0; l < ara_sys_pkg::NrLevels; l++) begin : g_level
    for (genvar n = 0; n < (1 << l); n++) begin : g_node
      cmd_fork_node i_fork (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .up_i   (tree_if[(1 << l) + n]),
        .dn_a_o (tree_if[2 * ((1 << l) + n)]),
        .dn_b_o (tree_if[2 * ((1 << l) + n) + 1])
      );
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Clusters and ring
  ////////////////////////////////////////////////////////////////////////////

  for (genvar c = 0; c < ara_sys_pkg::NrClusters; c++) begin : g_cluster
    vec_cluster i_cluster (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .cluster_id_i    (4'(c)),
      .cmd_i           (tree_if[ara_sys_pkg::NrClusters + c]),
      .ring_tx_valid_o (tx_valid[c]),
      .ring_tx_ready_i (tx_ready[c]),
      .ring_tx_data_o  (tx_data[c]),
      .ring_rx_valid_i (rx_valid[c]),
      .ring_rx_ready_o (rx_ready[c]),
      .ring_rx_data_i  (rx_data[c])
    );

    // Last spill wraps back to cluster 0
    ring_spill i_spill (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .valid_i (tx_valid[c]),
      .ready_o (tx_ready[c]),
      .data_i  (tx_data[c]),
      .valid_o (rx_valid[(c + 1) % ara_sys_pkg::NrClusters]),
      .ready_i (rx_ready[(c + 1) % ara_sys_pkg::NrClusters]),
      .data_o  (rx_data[(c + 1) % ara_sys_pkg::NrClusters])
    );
  end

endmodule

//--- source/cluster_ctrl.sv
`timescale 1ns/100ps

module cluster_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   cmd_valid_i,
  output logic                   cmd_ready_o,
  input  ara_sys_pkg::cmd_word_u cmd_i,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output ara_sys_pkg::elem_t     rsp_data_o,
  cluster_cmd_if.parent          tree_o
);

  logic [$clog2(ara_sys_pkg::MaxOutstanding+1)-1:0] cnt_q;
  logic [$clog2(ara_sys_pkg::MaxOutstanding+1)-1:0] cnt_d;
  ara_sys_pkg::cmd_word_u cmd_q;
  ara_sys_pkg::elem_t     rsp_data_q;
  logic                   cmd_valid_q;
  logic                   cmd_valid_d;
  logic                   ready_q;
  logic                   ready_d;
  logic                   rsp_valid_q;
  logic                   host_fire;
  logic                   tree_fire;
  logic                   done_fire;
  logic                   rsp_fire;

  assign host_fire = cmd_valid_i & ready_q;
  assign tree_fire = cmd_valid_q & tree_o.cmd_ready;
  assign done_fire = tree_o.done_valid & tree_o.done_ready;
  assign rsp_fire  = rsp_valid_q & rsp_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // Command path and in-flight count
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    cmd_valid_d = cmd_valid_q;
    if (tree_fire) cmd_valid_d = 1'b0;
    if (host_fire) cmd_valid_d = 1'b1;
    cnt_d = cnt_q;
    if (host_fire) cnt_d = cnt_d + 1'b1;
    if (rsp_fire) cnt_d = cnt_d - 1'b1;
    // Registered ready, so the host sees a flop
    ready_d = ~cmd_valid_d & (cnt_d < ara_sys_pkg::MaxOutstanding);
  end

  assign cmd_ready_o      = ready_q;
  assign tree_o.cmd_valid = cmd_valid_q;
  assign tree_o.cmd       = cmd_q;

  // Response register toward the host
  assign tree_o.done_ready = ~rsp_valid_q;
  assign rsp_valid_o       = rsp_valid_q;
  assign rsp_data_o        = rsp_data_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q       <= '0;
      cmd_valid_q <= 1'b0;
      ready_q     <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      cnt_q       <= cnt_d;
      cmd_valid_q <= cmd_valid_d;
      ready_q     <= ready_d;
      if (done_fire) rsp_valid_q <= 1'b1;
      else if (rsp_fire) rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (host_fire) cmd_q <= cmd_i;
    if (done_fire) rsp_data_q <= tree_o.done_data;
  end

endmodule

//--- source/vec_cluster.sv
`timescale 1ns/100ps

module vec_cluster (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic [3:0]         cluster_id_i,
  cluster_cmd_if.child       cmd_i,
  output logic               ring_tx_valid_o,
  input  logic               ring_tx_ready_i,
  output ara_sys_pkg::elem_t ring_tx_data_o,
  input  logic               ring_rx_valid_i,
  output logic               ring_rx_ready_o,
  input  ara_sys_pkg::elem_t ring_rx_data_i
);

  ara_sys_pkg::elem_t elem_q;
  ara_sys_pkg::elem_t tx_data_q;
  ara_sys_pkg::elem_t done_data_q;
  ara_sys_pkg::elem_t incr_ext;
  ara_sys_pkg::elem_t load_ext;
  logic               done_valid_q;
  logic               tx_pend_q;
  logic               rx_pend_q;
  logic               cmd_fire;
  logic               tx_fire;
  logic               rx_fire;
  logic               slide_done;
  logic               hit;

  // Busy while a completion waits or a slide is in progress
  assign cmd_i.cmd_ready = ~done_valid_q & ~tx_pend_q & ~rx_pend_q;
  assign cmd_fire        = cmd_i.cmd_valid & cmd_i.cmd_ready;

  assign cmd_i.done_valid = done_valid_q;
  assign cmd_i.done_data  = done_data_q;

  // Element view for LOAD and READ, arithmetic view for ADD
  assign hit      = cmd_i.cmd.elem.target == cluster_id_i;
  assign load_ext = {8'h00, cmd_i.cmd.elem.value};
  assign incr_ext = {{4{cmd_i.cmd.arith.incr[27]}}, cmd_i.cmd.arith.incr};

  ////////////////////////////////////////////////////////////////////////////
  // Ring side of SLIDE
  ////////////////////////////////////////////////////////////////////////////

  assign ring_tx_valid_o = tx_pend_q;
  assign ring_tx_data_o  = tx_data_q;
  assign ring_rx_ready_o = rx_pend_q;
  assign tx_fire         = ring_tx_valid_o & ring_tx_ready_i;
  assign rx_fire         = ring_rx_valid_i & ring_rx_ready_o;

  // Last outstanding half finishes this cycle
  assign slide_done = (tx_pend_q | rx_pend_q) & (~tx_pend_q | tx_fire) &
                      (~rx_pend_q | rx_fire);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      elem_q       <= '0;
      done_valid_q <= 1'b0;
      tx_pend_q    <= 1'b0;
      rx_pend_q    <= 1'b0;
    end else begin
      if (cmd_i.done_valid & cmd_i.done_ready) done_valid_q <= 1'b0;
      if (tx_fire) tx_pend_q <= 1'b0;
      if (rx_fire) begin
        rx_pend_q <= 1'b0;
        elem_q    <= ring_rx_data_i;
      end
      if (slide_done) done_valid_q <= 1'b1;
      if (cmd_fire) begin
        case (cmd_i.cmd.elem.opcode)
          ara_sys_pkg::OP_LOAD: begin
            if (hit) elem_q <= load_ext;
            done_valid_q <= 1'b1;
          end
          ara_sys_pkg::OP_ADD: begin
            elem_q       <= elem_q + incr_ext;
            done_valid_q <= 1'b1;
          end
          ara_sys_pkg::OP_SLIDE: begin
            tx_pend_q <= 1'b1;
            rx_pend_q <= 1'b1;
          end
          // READ and unknown opcodes just complete
          default: done_valid_q <= 1'b1;
        endcase
      end
    end
  end

  // Old element leaves on the ring, only READ hits return data
  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      tx_data_q <= elem_q;
      if (cmd_i.cmd.elem.opcode == ara_sys_pkg::OP_READ && hit) done_data_q <= elem_q;
      else done_data_q <= '0;
    end
  end

endmodule

//--- source/ring_spill.sv
`timescale 1ns/100ps

module ring_spill (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               valid_i,
  output logic               ready_o,
  input  ara_sys_pkg::elem_t data_i,
  output logic               valid_o,
  input  logic               ready_i,
  output ara_sys_pkg::elem_t data_o
);

  logic               a_full_q;
  logic               b_full_q;
  ara_sys_pkg::elem_t a_data_q;
  ara_sys_pkg::elem_t b_data_q;
  logic               a_fill;
  logic               a_drain;
  logic               b_fill;
  logic               b_drain;

  // Input side sees only local state, no path from ready_i
  assign ready_o = ~a_full_q | ~b_full_q;
  assign a_fill  = valid_i & ready_o;

  // A empties either to the output or into B when output stalls
  assign a_drain = a_full_q & ~b_full_q;
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  // B holds the older word whenever it is full
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill | a_drain) a_full_q <= a_fill;
      if (b_fill | b_drain) b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= data_i;
    if (b_fill) b_data_q <= a_data_q;
  end

endmodule

//--- source/cmd_fork_node.sv
`timescale 1ns/100ps

module cmd_fork_node (
  input  logic          clk_i,
  input  logic          rst_i,
  cluster_cmd_if.child  up_i,
  cluster_cmd_if.parent dn_a_o,
  cluster_cmd_if.parent dn_b_o
);

  ara_sys_pkg::cmd_word_u cmd_q;
  logic                   pend_a_q;
  logic                   pend_b_q;
  logic                   slot_a_full_q;
  logic                   slot_b_full_q;
  ara_sys_pkg::elem_t     slot_a_q;
  ara_sys_pkg::elem_t     slot_b_q;
  logic                   up_fire;
  logic                   done_a_fire;
  logic                   done_b_fire;
  logic                   join_fire;

  ////////////////////////////////////////////////////////////////////////////
  // Command fork
  ////////////////////////////////////////////////////////////////////////////

  // New command only once both children took the held one
  assign up_i.cmd_ready = ~pend_a_q & ~pend_b_q;
  assign up_fire        = up_i.cmd_valid & up_i.cmd_ready;

  assign dn_a_o.cmd_valid = pend_a_q;
  assign dn_a_o.cmd       = cmd_q;
  assign dn_b_o.cmd_valid = pend_b_q;
  assign dn_b_o.cmd       = cmd_q;

  ////////////////////////////////////////////////////////////////////////////
  // Completion join
  ////////////////////////////////////////////////////////////////////////////

  assign dn_a_o.done_ready = ~slot_a_full_q;
  assign dn_b_o.done_ready = ~slot_b_full_q;
  assign done_a_fire       = dn_a_o.done_valid & dn_a_o.done_ready;
  assign done_b_fire       = dn_b_o.done_valid & dn_b_o.done_ready;

  // At most one child returns nonzero data (READ), so OR merges the pair
  assign up_i.done_valid = slot_a_full_q & slot_b_full_q;
  assign up_i.done_data  = slot_a_q | slot_b_q;
  assign join_fire       = up_i.done_valid & up_i.done_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_a_q      <= 1'b0;
      pend_b_q      <= 1'b0;
      slot_a_full_q <= 1'b0;
      slot_b_full_q <= 1'b0;
    end else begin
      if (up_fire) begin
        pend_a_q <= 1'b1;
        pend_b_q <= 1'b1;
      end else begin
        if (dn_a_o.cmd_ready) pend_a_q <= 1'b0;
        if (dn_b_o.cmd_ready) pend_b_q <= 1'b0;
      end
      if (done_a_fire) slot_a_full_q <= 1'b1;
      else if (join_fire) slot_a_full_q <= 1'b0;
      if (done_b_fire) slot_b_full_q <= 1'b1;
      else if (join_fire) slot_b_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (up_fire) cmd_q <= up_i.cmd;
    if (done_a_fire) slot_a_q <= dn_a_o.done_data;
    if (done_b_fire) slot_b_q <= dn_b_o.done_data;
  end

endmodule

//--- source/cluster_cmd_if.sv
`timescale 1ns/100ps

interface cluster_cmd_if;

  // Command toward the clusters
  logic                   cmd_valid;
  logic                   cmd_ready;
  ara_sys_pkg::cmd_word_u cmd;

  // Completion back toward the host
  logic                   done_valid;
  logic                   done_ready;
  ara_sys_pkg::elem_t     done_data;

  modport parent (
    output cmd_valid, cmd, done_ready,
    input  cmd_ready, done_valid, done_data
  );

  modport child (
    input  cmd_valid, cmd, done_ready,
    output cmd_ready, done_valid, done_data
  );

endinterface

//--- source/ara_sys_pkg.sv
package ara_sys_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // System size
  ////////////////////////////////////////////////////////////////////////////

  // Must stay a power of two, the fork tree is a full binary tree
  localparam int unsigned NrClusters     = 4;
  localparam int unsigned NrLevels       = $clog2(NrClusters);
  localparam int unsigned ElemWidth      = 32;
  // Commands in flight between host accept and response
  localparam int unsigned MaxOutstanding = 4;

  // One element of the distributed vector, also the response word
  typedef logic [ElemWidth-1:0] elem_t;

  ////////////////////////////////////////////////////////////////////////////
  // Command word
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    OP_LOAD  = 4'h0,
    OP_READ  = 4'h1,
    OP_ADD   = 4'h2,
    OP_SLIDE = 4'h3
  } opcode_e;

  // LOAD and READ view
  typedef struct packed {
    opcode_e     opcode;
    logic [3:0]  target;
    logic [23:0] value;
  } cmd_elem_t;

  // ADD view, increment is sign extended to the element width
  typedef struct packed {
    opcode_e            opcode;
    logic signed [27:0] incr;
  } cmd_arith_t;

  // Opcode sits in the top nibble of both views
  typedef union packed {
    cmd_elem_t  elem;
    cmd_arith_t arith;
  } cmd_word_u;

endpackage
